//--- common/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] creg_addr_t;

    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,   // Load or fetch address error
        EXC_ADES = 5'd5,   // Store address error
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic [15:0] zero_31_16;
        logic [7:0]  IM;
        logic [4:0]  zero_7_3;
        logic        ERL;
        logic        EXL;
        logic        IE;
    } status_t;

    typedef struct packed {
        logic        BD;
        logic        TI;
        logic [13:0] zero_29_16;
        logic [7:0]  IP;   // IP[7] timer, IP[6:2] hardware, IP[1:0] software
        logic        zero_7;
        exc_code_t   exccode;
        logic [1:0]  zero_1_0;
    } cause_t;

    typedef struct packed {
        word_t   badvaddr;
        word_t   count;
        word_t   compare;
        status_t status;
        cause_t  cause;
        word_t   epc;
        word_t   config_;
    } cp0_regs_t;

    typedef struct packed {
        logic      valid;
        exc_code_t code;
        word_t     pc;
        word_t     badvaddr;
        logic      in_delay_slot;
    } exception_t;

    typedef struct packed {
        logic       wen;
        creg_addr_t addr;
        word_t      wd;
    } cp0_write_t;

    localparam creg_addr_t CREG_BADVADDR = 5'd8;
    localparam creg_addr_t CREG_COUNT    = 5'd9;
    localparam creg_addr_t CREG_COMPARE  = 5'd11;
    localparam creg_addr_t CREG_STATUS   = 5'd12;
    localparam creg_addr_t CREG_CAUSE    = 5'd13;
    localparam creg_addr_t CREG_EPC      = 5'd14;
    localparam creg_addr_t CREG_CONFIG   = 5'd16;

    localparam word_t EXC_VECTOR  = 32'hBFC0_0380;
    localparam word_t CONFIG_INIT = 32'h8000_0082;   // M set, kseg0 uncached

    // Core comes out of reset in error level
    localparam status_t STATUS_INIT = '{
        zero_31_16: '0, IM: '0, zero_7_3: '0, ERL: 1'b1, EXL: 1'b0, IE: 1'b0
    };

    localparam cp0_regs_t CP0_INIT = '{
        badvaddr: '0, count: '0, compare: '0, status: STATUS_INIT,
        cause: '0, epc: '0, config_: CONFIG_INIT
    };

endpackage

//--- common/cp0_intf.sv
interface cp0_intf
    import mips_pkg::*;
();
    cp0_write_t cwrite;            // mtc0 strobe, address and data
    creg_addr_t ra;                // mfc0 register number
    word_t      rd;
    logic [4:0] int_hw;            // Hardware interrupt lines into Cause.IP[6:2]
    logic       timer_interrupt;
    cp0_regs_t  regs;

    modport top (
        output cwrite, ra, int_hw,
        input  rd, timer_interrupt, regs
    );

    modport cp0 (
        input  cwrite, ra, int_hw,
        output rd, timer_interrupt, regs
    );
endinterface

//--- common/exception_intf.sv
interface exception_intf
    import mips_pkg::*;
();
    exception_t exception;
    logic       eret_taken;
    status_t    status;
    cause_t     cause;
    word_t      epc;   // Return target for eret

    modport arb (
        output exception, eret_taken,
        input  status, cause, epc
    );

    modport cp0 (
        input  exception, eret_taken,
        output status, cause, epc
    );
endinterface

//--- cp0/cp0.sv
module cp0
    import mips_pkg::*;
(
    input logic clk,
    input logic reset,
    cp0_intf.cp0 ports,
    exception_intf.cp0 excep
);
    cp0_regs_t  regs_q;
    cp0_regs_t  regs_d;
    cp0_write_t cwrite;
    exception_t exc;
    logic       count_phase;
    logic       timer_irq;
    logic       timer_irq_d;
    logic       compare_write;

    assign cwrite = ports.cwrite;
    assign exc = excep.exception;
    assign compare_write = cwrite.wen && (cwrite.addr == CREG_COMPARE);

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            regs_q <= CP0_INIT;
        end else begin
            regs_q <= regs_d;
        end
    end

    // Count advances on every other edge
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count_phase <= 1'b0;
        end else begin
            count_phase <= ~count_phase;
        end
    end

    always_comb begin
        timer_irq_d = timer_irq;
        if (compare_write) begin
            timer_irq_d = 1'b0;   // Writing Compare acknowledges the timer
        end else if (regs_q.count == regs_q.compare) begin
            timer_irq_d = 1'b1;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= timer_irq_d;
        end
    end

    // mfc0 read port
    always_comb begin
        case (ports.ra)
            CREG_BADVADDR: ports.rd = regs_q.badvaddr;
            CREG_COUNT:    ports.rd = regs_q.count;
            CREG_COMPARE:  ports.rd = regs_q.compare;
            CREG_STATUS:   ports.rd = regs_q.status;
            CREG_CAUSE:    ports.rd = regs_q.cause;
            CREG_EPC:      ports.rd = regs_q.epc;
            CREG_CONFIG:   ports.rd = regs_q.config_;
            default:       ports.rd = '0;
        endcase
    end

    always_comb begin
        regs_d = regs_q;
        regs_d.count = regs_q.count + {31'b0, count_phase};
        regs_d.cause.IP[7] = timer_irq_d;
        regs_d.cause.TI = timer_irq_d;
        regs_d.cause.IP[6:2] = ports.int_hw;

        if (cwrite.wen) begin
            case (cwrite.addr)
                CREG_COUNT:   regs_d.count = cwrite.wd;
                CREG_COMPARE: regs_d.compare = cwrite.wd;
                CREG_STATUS: begin
                    regs_d.status.IM = cwrite.wd[15:8];
                    regs_d.status.EXL = cwrite.wd[1];
                    regs_d.status.IE = cwrite.wd[0];
                end
                CREG_CAUSE:   regs_d.cause.IP[1:0] = cwrite.wd[9:8];
                CREG_EPC:     regs_d.epc = cwrite.wd;
                default: ;
            endcase
        end

        // Exception fields override a same-cycle mtc0
        if (exc.valid) begin
            if (!regs_q.status.EXL) begin   // Nested faults keep the first EPC
                regs_d.cause.BD = exc.in_delay_slot;
                regs_d.epc = exc.in_delay_slot ? exc.pc - 32'd4 : exc.pc;
            end
            regs_d.cause.exccode = exc.code;
            regs_d.status.EXL = 1'b1;
            if (exc.code == EXC_ADEL || exc.code == EXC_ADES) begin
                regs_d.badvaddr = exc.badvaddr;
            end
        end

        if (excep.eret_taken) begin
            if (regs_q.status.ERL) begin
                regs_d.status.ERL = 1'b0;
            end else begin
                regs_d.status.EXL = 1'b0;
            end
        end
    end

    assign ports.timer_interrupt = timer_irq;
    assign ports.regs = regs_q;
    assign excep.status = regs_q.status;
    assign excep.cause = regs_q.cause;
    assign excep.epc = regs_q.epc;
endmodule

//--- source/fault_check.sv
module fault_check
    import mips_pkg::*;
(
    input  word_t      pc,
    input  logic       inst_valid,
    input  logic       in_delay_slot,
    input  logic       is_syscall,
    input  logic       is_break,
    input  logic       is_ri,
    input  logic       overflow,
    input  logic       mem_read,
    input  logic       mem_write,
    input  word_t      mem_addr,
    input  mem_size_t  mem_size,
    output exception_t fault
);
    logic fetch_misaligned;
    logic addr_misaligned;

    assign fetch_misaligned = pc[1:0] != 2'b00;

    always_comb begin
        case (mem_size)
            SIZE_HALF: addr_misaligned = mem_addr[0];
            SIZE_WORD: addr_misaligned = mem_addr[1:0] != 2'b00;
            default:   addr_misaligned = 1'b0;   // Byte accesses always aligned
        endcase
    end

    // Highest priority fault first
    always_comb begin
        fault = '0;
        fault.pc = pc;
        fault.in_delay_slot = in_delay_slot;
        fault.code = EXC_INT;
        if (inst_valid) begin
            fault.valid = 1'b1;
            if (fetch_misaligned) begin
                fault.code = EXC_ADEL;
                fault.badvaddr = pc;
            end else if (is_ri) begin
                fault.code = EXC_RI;
            end else if (is_syscall) begin
                fault.code = EXC_SYS;
            end else if (is_break) begin
                fault.code = EXC_BP;
            end else if (overflow) begin
                fault.code = EXC_OV;
            end else if (mem_read && addr_misaligned) begin
                fault.code = EXC_ADEL;
                fault.badvaddr = mem_addr;
            end else if (mem_write && addr_misaligned) begin
                fault.code = EXC_ADES;
                fault.badvaddr = mem_addr;
            end else begin
                fault.valid = 1'b0;
            end
        end
    end
endmodule

//--- source/exception_arbiter.sv
module exception_arbiter
    import mips_pkg::*;
(
    input  logic       inst_valid,
    input  logic       is_eret,
    input  exception_t fault,
    exception_intf.arb excep,
    output logic       exc_taken,
    output logic       eret_taken,
    output word_t      redirect_pc
);
    logic       int_pending;
    exception_t taken;

    // Uses the registered Status and Cause
    assign int_pending = (|(excep.cause.IP & excep.status.IM))
                         && excep.status.IE
                         && !excep.status.EXL
                         && !excep.status.ERL;

    always_comb begin
        if (inst_valid && int_pending) begin
            taken = '0;
            taken.valid = 1'b1;
            taken.code = EXC_INT;
            taken.pc = fault.pc;
            taken.in_delay_slot = fault.in_delay_slot;
        end else begin
            taken = fault;
        end
    end

    assign exc_taken = taken.valid;
    assign eret_taken = inst_valid && is_eret && !taken.valid;

    always_comb begin
        if (taken.valid) begin
            redirect_pc = EXC_VECTOR;
        end else begin
            redirect_pc = excep.epc;   // Only meaningful with eret_taken
        end
    end

    assign excep.exception = taken;
    assign excep.eret_taken = eret_taken;
endmodule

//--- source/cp0_subsys.sv
module cp0_subsys
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       inst_valid,
    input  word_t      pc,
    input  logic       in_delay_slot,
    input  logic       is_syscall,
    input  logic       is_break,
    input  logic       is_ri,
    input  logic       overflow,
    input  logic       mem_read,
    input  logic       mem_write,
    input  word_t      mem_addr,
    input  mem_size_t  mem_size,
    input  logic       is_eret,
    input  logic [4:0] int_hw,
    input  logic       cwrite_en,
    input  creg_addr_t cwrite_addr,
    input  word_t      cwrite_data,
    input  creg_addr_t read_addr,
    output word_t      read_data,
    output logic       exc_taken,
    output logic       eret_taken,
    output word_t      redirect_pc
);
    exception_t fault;

    cp0_intf ports_if ();
    exception_intf excep_if ();

    assign ports_if.cwrite = '{wen: cwrite_en, addr: cwrite_addr, wd: cwrite_data};
    assign ports_if.ra = read_addr;
    assign ports_if.int_hw = int_hw;
    assign read_data = ports_if.rd;

    fault_check i_fault_check (
        .pc            (pc),
        .inst_valid    (inst_valid),
        .in_delay_slot (in_delay_slot),
        .is_syscall    (is_syscall),
        .is_break      (is_break),
        .is_ri         (is_ri),
        .overflow      (overflow),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_size      (mem_size),
        .fault         (fault)
    );

    exception_arbiter i_exception_arbiter (
        .inst_valid  (inst_valid),
        .is_eret     (is_eret),
        .fault       (fault),
        .excep       (excep_if.arb),
        .exc_taken   (exc_taken),
        .eret_taken  (eret_taken),
        .redirect_pc (redirect_pc)
    );

    cp0 i_cp0 (
        .clk   (clk),
        .reset (reset),
        .ports (ports_if.cp0),
        .excep (excep_if.cp0)
    );
endmodule

//--- tb/cp0_subsys_sva.sv
module cp0_subsys_sva
    import mips_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input logic    exc_taken,
    input logic    eret_taken,
    input word_t   redirect_pc,
    input status_t status
);
    timeunit 1ns;
    timeprecision 1ps;

    // An exception always suppresses eret
    assert property (@(posedge clk) disable iff (reset) !(exc_taken && eret_taken))
        else $error("exc_taken and eret_taken high in the same cycle");

    assert property (@(posedge clk) disable iff (reset)
        exc_taken |-> redirect_pc == EXC_VECTOR)
        else $error("Exception redirect differs from the exception vector");

    assert property (@(posedge clk) disable iff (reset) exc_taken |=> status.EXL)
        else $error("Status.EXL not set in the cycle after a taken exception");
endmodule

//--- tb/tb_cp0_subsys.sv
module tb_cp0_subsys
    import mips_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int WATCHDOG_CYCLES = 400;

    // Instruction flag bits for issue
    localparam logic [6:0] F_NONE  = 7'h00;
    localparam logic [6:0] F_RI    = 7'h01;
    localparam logic [6:0] F_SYS   = 7'h02;
    localparam logic [6:0] F_BRK   = 7'h04;
    localparam logic [6:0] F_OV    = 7'h08;
    localparam logic [6:0] F_LOAD  = 7'h10;
    localparam logic [6:0] F_STORE = 7'h20;
    localparam logic [6:0] F_ERET  = 7'h40;

    logic       clk;
    logic       reset;
    logic       inst_valid;
    word_t      pc;
    logic       in_delay_slot;
    logic       is_syscall;
    logic       is_break;
    logic       is_ri;
    logic       overflow;
    logic       mem_read;
    logic       mem_write;
    word_t      mem_addr;
    mem_size_t  mem_size;
    logic       is_eret;
    logic [4:0] int_hw;
    logic       cwrite_en;
    creg_addr_t cwrite_addr;
    word_t      cwrite_data;
    creg_addr_t read_addr;
    word_t      read_data;
    logic       exc_taken;
    logic       eret_taken;
    word_t      redirect_pc;

    integer seed = 72;
    int     error_count = 0;
    int     check_count = 0;

    cp0_subsys i_cp0_subsys (.*);

    bind cp0_subsys cp0_subsys_sva i_cp0_subsys_sva (
        .clk         (clk),
        .reset       (reset),
        .exc_taken   (exc_taken),
        .eret_taken  (eret_taken),
        .redirect_pc (redirect_pc),
        .status      (excep_if.status)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_word(input word_t actual, input word_t expected, input string msg);
        check_count++;
        if (actual !== expected) begin
            $display("ERR %0t: %s got %h expected %h", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_code(input exc_code_t actual, input exc_code_t expected,
                              input string msg);
        check_count++;
        if (actual !== expected) begin
            $display("ERR %0t: %s got %0d expected %0d (%s)", $time, msg, actual, expected,
                     expected.name());
            error_count++;
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string msg);
        check_count++;
        if (actual !== expected) begin
            $display("ERR %0t: %s got %b expected %b", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    function automatic word_t random_pc();
        return {$random(seed)} & 32'hFFFF_FFFC;
    endfunction

    task automatic mtc0(input creg_addr_t addr, input word_t data);
        @(posedge clk);
        cwrite_en <= 1'b1;
        cwrite_addr <= addr;
        cwrite_data <= data;
        @(posedge clk);   // Write lands on this edge
        cwrite_en <= 1'b0;
    endtask

    task automatic read_reg(input creg_addr_t addr, output word_t value);
        @(posedge clk);
        read_addr <= addr;
        @(negedge clk);
        value = read_data;
    endtask

    task automatic mfc0_expect(input creg_addr_t addr, input word_t expected, input string msg);
        word_t value;
        read_reg(addr, value);
        check_word(value, expected, msg);
    endtask

    // One memory-stage instruction for one cycle
    task automatic issue(input word_t ipc, input logic ds, input logic [6:0] flags,
                         input word_t addr, input mem_size_t size, input logic exp_exc,
                         input logic exp_eret, input word_t exp_redirect);
        @(posedge clk);
        inst_valid <= 1'b1;
        pc <= ipc;
        in_delay_slot <= ds;
        {is_eret, mem_write, mem_read, overflow, is_break, is_syscall, is_ri} <= flags;
        mem_addr <= addr;
        mem_size <= size;
        @(negedge clk);
        check_bit(exc_taken, exp_exc, "exc_taken");
        check_bit(eret_taken, exp_eret, "eret_taken");
        if (exp_exc || exp_eret) begin
            check_word(redirect_pc, exp_redirect, "redirect_pc");
        end
        @(posedge clk);
        inst_valid <= 1'b0;
        {is_eret, mem_write, mem_read, overflow, is_break, is_syscall, is_ri} <= F_NONE;
    endtask

    task automatic wait_timer();
        word_t value;
        int    cycles;
        value = '0;
        cycles = 0;
        while (!value[15] && cycles < 12) begin
            read_reg(CREG_CAUSE, value);
            cycles++;
        end
        check_count++;
        if (!value[15]) begin
            $display("Timer interrupt did not reach Cause.IP[7] within 12 cycles");
            error_count++;
        end
    endtask

    task automatic fault_case(input word_t ipc, input logic ds, input logic [6:0] flags,
                              input word_t addr, input mem_size_t size,
                              input exc_code_t exp_code);
        word_t value;
        mtc0(CREG_STATUS, 32'h0);   // Clear EXL so EPC is captured
        issue(ipc, ds, flags, addr, size, 1'b1, 1'b0, EXC_VECTOR);
        read_reg(CREG_CAUSE, value);
        check_code(exc_code_t'(value[6:2]), exp_code, "Cause.ExcCode");
        check_bit(value[31], ds, "Cause.BD");
        mfc0_expect(CREG_EPC, ds ? ipc - 32'd4 : ipc, "EPC");
    endtask

    task automatic register_access();
        word_t value;
        check_bit(exc_taken, 1'b0, "exc_taken after reset");
        check_bit(eret_taken, 1'b0, "eret_taken after reset");
        mfc0_expect(CREG_STATUS, 32'h0000_0004, "Status after reset");
        value = $random(seed);
        mtc0(CREG_EPC, value);
        mfc0_expect(CREG_EPC, value, "EPC readback");
        value = $random(seed);
        mtc0(CREG_COMPARE, value);
        mfc0_expect(CREG_COMPARE, value, "Compare readback");
        value = $random(seed);
        mtc0(CREG_STATUS, value);
        mfc0_expect(CREG_STATUS, (value & 32'h0000_FF03) | 32'h4, "Status readback");
        mtc0(CREG_STATUS, 32'h0);
        mtc0(CREG_BADVADDR, $random(seed));
        mfc0_expect(CREG_BADVADDR, 32'h0, "BadVAddr is read only");
        mtc0(CREG_CONFIG, $random(seed));
        mfc0_expect(CREG_CONFIG, CONFIG_INIT, "Config is read only");
        // ERL from reset still blocks an enabled hardware interrupt
        @(posedge clk);
        int_hw <= 5'b00001;
        mtc0(CREG_STATUS, 32'h0000_0401);
        issue(random_pc(), 1'b0, F_NONE, 32'h0, SIZE_WORD, 1'b0, 1'b0, 32'h0);
        @(posedge clk);
        int_hw <= 5'b0;
        mtc0(CREG_STATUS, 32'h0);
    endtask

    task automatic fault_priority();
        word_t ipc;
        word_t addr;
        ipc = random_pc();
        addr = random_pc();
        fault_case(ipc, 1'b0, F_RI, addr, SIZE_WORD, EXC_RI);
        fault_case(ipc, 1'b0, F_SYS, addr, SIZE_WORD, EXC_SYS);
        fault_case(ipc, 1'b0, F_BRK, addr, SIZE_WORD, EXC_BP);
        fault_case(ipc, 1'b0, F_OV, addr, SIZE_WORD, EXC_OV);
        fault_case(ipc, 1'b0, F_LOAD, addr | 32'h2, SIZE_WORD, EXC_ADEL);
        mfc0_expect(CREG_BADVADDR, addr | 32'h2, "BadVAddr misaligned load");
        fault_case(ipc, 1'b0, F_STORE, addr | 32'h1, SIZE_HALF, EXC_ADES);
        mfc0_expect(CREG_BADVADDR, addr | 32'h1, "BadVAddr misaligned store");
        fault_case(ipc | 32'h2, 1'b0, F_NONE, addr, SIZE_WORD, EXC_ADEL);
        mfc0_expect(CREG_BADVADDR, ipc | 32'h2, "BadVAddr misaligned fetch");
        fault_case(ipc, 1'b1, F_SYS, addr, SIZE_WORD, EXC_SYS);   // Delay slot
        // Pairs where the higher priority fault wins
        fault_case(ipc | 32'h1, 1'b0, F_RI, addr, SIZE_WORD, EXC_ADEL);
        mfc0_expect(CREG_BADVADDR, ipc | 32'h1, "BadVAddr fetch over RI");
        fault_case(ipc, 1'b0, F_RI | F_SYS, addr, SIZE_WORD, EXC_RI);
        fault_case(ipc, 1'b0, F_SYS | F_BRK, addr, SIZE_WORD, EXC_SYS);
        fault_case(ipc, 1'b0, F_BRK | F_OV, addr, SIZE_WORD, EXC_BP);
        fault_case(ipc, 1'b0, F_OV | F_STORE, addr | 32'h3, SIZE_WORD, EXC_OV);
        fault_case(ipc, 1'b0, F_LOAD | F_STORE, addr | 32'h1, SIZE_HALF, EXC_ADEL);
        // Aligned half and any byte access raise nothing
        issue(ipc, 1'b0, F_LOAD, addr | 32'h2, SIZE_HALF, 1'b0, 1'b0, 32'h0);
        issue(ipc, 1'b0, F_STORE, addr | 32'h3, SIZE_BYTE, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic nesting_and_eret();
        word_t first_pc;
        word_t second_pc;
        word_t value;
        first_pc = random_pc();
        second_pc = random_pc();
        fault_case(first_pc, 1'b0, F_SYS, 32'h0, SIZE_WORD, EXC_SYS);
        issue(second_pc, 1'b1, F_BRK, 32'h0, SIZE_WORD, 1'b1, 1'b0, EXC_VECTOR);
        read_reg(CREG_CAUSE, value);
        check_code(exc_code_t'(value[6:2]), EXC_BP, "nested ExcCode");
        check_bit(value[31], 1'b0, "Cause.BD kept on nested fault");
        mfc0_expect(CREG_EPC, first_pc, "EPC kept on nested fault");
        issue(second_pc, 1'b0, F_ERET, 32'h0, SIZE_WORD, 1'b0, 1'b1, first_pc);
        mfc0_expect(CREG_STATUS, 32'h0000_0002, "Status after first eret");   // ERL gone
        issue(second_pc, 1'b0, F_ERET, 32'h0, SIZE_WORD, 1'b0, 1'b1, first_pc);
        mfc0_expect(CREG_STATUS, 32'h0000_0000, "Status after second eret");
        issue(second_pc, 1'b0, F_ERET | F_OV, 32'h0, SIZE_WORD, 1'b1, 1'b0, EXC_VECTOR);
        mtc0(CREG_STATUS, 32'h0);
    endtask

    task automatic interrupt_gating();
        int    line;
        word_t im_bit;
        word_t ipc;
        word_t value;
        line = {$random(seed)} % 5;
        im_bit = 32'h0000_0100 << (line + 2);   // IM bit matching IP[line + 2]
        ipc = random_pc();
        @(posedge clk);
        int_hw <= 5'b00001 << line;
        mtc0(CREG_STATUS, im_bit);
        issue(ipc, 1'b0, F_NONE, 32'h0, SIZE_WORD, 1'b0, 1'b0, 32'h0);
        mtc0(CREG_STATUS, im_bit | 32'h3);
        issue(ipc, 1'b0, F_NONE, 32'h0, SIZE_WORD, 1'b0, 1'b0, 32'h0);
        mtc0(CREG_STATUS, 32'h1);
        issue(ipc, 1'b0, F_NONE, 32'h0, SIZE_WORD, 1'b0, 1'b0, 32'h0);
        mtc0(CREG_STATUS, im_bit | 32'h1);
        issue(ipc, 1'b0, F_BRK, 32'h0, SIZE_WORD, 1'b1, 1'b0, EXC_VECTOR);
        read_reg(CREG_CAUSE, value);
        check_code(exc_code_t'(value[6:2]), EXC_INT, "interrupt over break");
        mfc0_expect(CREG_EPC, ipc, "EPC on interrupt");
        @(posedge clk);
        int_hw <= 5'b0;
        mtc0(CREG_STATUS, 32'h0);
    endtask

    task automatic timer_compare();
        word_t count_now;
        word_t value;
        mtc0(CREG_STATUS, 32'h0000_8001);   // Timer line and IE only
        read_reg(CREG_COUNT, count_now);
        mtc0(CREG_COMPARE, count_now + 32'd3);
        read_reg(CREG_CAUSE, value);
        check_bit(value[15], 1'b0, "Cause.IP[7] before the match");
        wait_timer();
        issue(random_pc(), 1'b0, F_NONE, 32'h0, SIZE_WORD, 1'b1, 1'b0, EXC_VECTOR);
        read_reg(CREG_CAUSE, value);
        check_code(exc_code_t'(value[6:2]), EXC_INT, "timer ExcCode");
        mtc0(CREG_COMPARE, count_now + 32'h1000);
        read_reg(CREG_CAUSE, value);
        check_bit(value[15], 1'b0, "Cause.IP[7] after Compare write");
    endtask

    initial begin
        reset = 1'b1;
        inst_valid = 1'b0;
        pc = '0;
        in_delay_slot = 1'b0;
        is_syscall = 1'b0;
        is_break = 1'b0;
        is_ri = 1'b0;
        overflow = 1'b0;
        mem_read = 1'b0;
        mem_write = 1'b0;
        mem_addr = '0;
        mem_size = SIZE_WORD;
        is_eret = 1'b0;
        int_hw = '0;
        cwrite_en = 1'b0;
        cwrite_addr = '0;
        cwrite_data = '0;
        read_addr = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        register_access();
        fault_priority();
        nesting_and_eret();
        interrupt_gating();
        timer_compare();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end
endmodule

//--- compile.f
common/mips_pkg.sv
common/cp0_intf.sv
common/exception_intf.sv
cp0/cp0.sv
source/fault_check.sv
source/exception_arbiter.sv
source/cp0_subsys.sv
tb/cp0_subsys_sva.sv
tb/tb_cp0_subsys.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f \
        --top-module tb_cp0_subsys --Mdir obj_dir -o tb_cp0_subsys; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cp0_subsys)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
